/* Makefile */
SRCS := $(filter %.sv,$(shell cat list.f))

all: run

obj_dir/Vspim_tb: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module spim_tb -f list.f

run: obj_dir/Vspim_tb
	./obj_dir/Vspim_tb | tee sim.log
	@! grep -q "test failed" sim.log
	@grep -q "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* list.f */
spim_pkg.sv
spim_fifo.sv
spim_engine.sv
spim_reg.sv
spim_wb_slave.sv
spim_top.sv
tb_clk_gen.sv
spim_tb.sv

/* spim_engine.sv */
/*
  spim shift engine
  mode 0, msb first; pops wbuf per word, shifts out and in, pushes rbuf
  clears the transfer through trans_done
*/
`timescale 1ns/1ps

module spim_engine #(
  parameter int FIFO_ADDR_WIDTH = 4
) (
  input  logic                              aclk,
  input  logic                              arst_n,
  input  logic [spim_pkg::DATA_W-1:0]       cmd,
  input  logic [spim_pkg::DATA_W-1:0]       wbuf_data,
  input  logic                              miso,
  output logic                              wbuf_pop,
  output logic                              rbuf_push,
  output logic [spim_pkg::DATA_W-1:0]       rbuf_data,
  output logic                              word_done,
  output logic                              trans_done,
  output logic                              busy,
  output logic [4:0]                        words_sent,
  output logic [spim_pkg::DATA_W-1:0]       bit_state,
  output logic                              sclk,
  output logic                              mosi,
  output logic [spim_pkg::CS_N_W-1:0]       cs_n
);

  // no transfer longer than a fifo holds
  localparam int FIFO_DEPTH = 1 << FIFO_ADDR_WIDTH;
  localparam int MAX_WORDS  = (FIFO_DEPTH > 16) ? 16 : FIFO_DEPTH;

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_LOAD   = 2'd1;
  localparam logic [1:0] ST_SHIFT  = 2'd2;
  localparam logic [1:0] ST_FINISH = 2'd3;

  logic [1:0]                  state;
  logic [7:0]                  div_q;
  logic [7:0]                  div_cnt;
  logic                        half;
  logic [4:0]                  bit_cnt;
  logic [4:0]                  last_word;
  logic [spim_pkg::DATA_W-1:0] tx_sr;
  logic [spim_pkg::DATA_W-1:0] rx_sr;
  logic [3:0]                  cmd_cnt;
  logic [1:0]                  cmd_cs;
  logic                        half_end;
  logic                        word_end;

  assign cmd_cnt = cmd[spim_pkg::CMD_CNT_MSB:spim_pkg::CMD_CNT_LSB];
  assign cmd_cs  = cmd[spim_pkg::CMD_CS_MSB:spim_pkg::CMD_CS_LSB];

  // half bit ends after div+1 cycles
  assign half_end = (state == ST_SHIFT) && (div_cnt == div_q);
  // second half of bit 31
  assign word_end = half_end && half && (bit_cnt == 5'd31);

  assign wbuf_pop   = (state == ST_LOAD);
  assign rbuf_push  = word_end;
  assign rbuf_data  = rx_sr;
  assign word_done  = word_end;
  assign trans_done = (state == ST_FINISH);
  assign busy       = (state != ST_IDLE);
  assign mosi       = tx_sr[spim_pkg::DATA_W-1];

  // diagnostic snapshot
  assign bit_state = {state, 6'b0, div_cnt, 7'b0, half, 3'b0, bit_cnt};

  //////////////////////////////
  // transfer fsm
  //////////////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_IDLE;
      div_q      <= '0;
      div_cnt    <= '0;
      half       <= 1'b0;
      bit_cnt    <= '0;
      last_word  <= '0;
      words_sent <= '0;
      tx_sr      <= '0;
      rx_sr      <= '0;
      sclk       <= 1'b0;
      cs_n       <= '1;
    end else begin
      case (state)
        ST_IDLE: begin
          if (cmd[spim_pkg::CMD_START_BIT]) begin
            state      <= ST_LOAD;
            words_sent <= '0;
            div_q      <= cmd[spim_pkg::CMD_DIV_MSB:spim_pkg::CMD_DIV_LSB];
            last_word  <= (int'(cmd_cnt) >= MAX_WORDS) ? 5'(MAX_WORDS - 1)
                                                       : {1'b0, cmd_cnt};
            // one select low for the whole transfer
            cs_n       <= ~(spim_pkg::CS_N_W'(1) << cmd_cs);
          end
        end
        ST_LOAD: begin
          // head word, zero on underflow
          tx_sr   <= wbuf_data;
          div_cnt <= '0;
          half    <= 1'b0;
          bit_cnt <= '0;
          state   <= ST_SHIFT;
        end
        ST_SHIFT: begin
          if (!half_end) begin
            div_cnt <= div_cnt + 1'b1;
          end else begin
            div_cnt <= '0;
            half    <= ~half;
            sclk    <= ~half;
            if (!half) begin
              // rising edge, sample
              rx_sr <= {rx_sr[spim_pkg::DATA_W-2:0], miso};
            end else if (bit_cnt == 5'd31) begin
              words_sent <= words_sent + 1'b1;
              state      <= (words_sent == last_word) ? ST_FINISH : ST_LOAD;
            end else begin
              // next bit out on the falling edge
              bit_cnt <= bit_cnt + 1'b1;
              tx_sr   <= {tx_sr[spim_pkg::DATA_W-2:0], 1'b0};
            end
          end
        end
        default: begin
          cs_n  <= '1;
          state <= ST_IDLE;
        end
      endcase
    end
  end

  a_cs_onehot : assert property (@(posedge aclk) disable iff (!arst_n)
    $onehot0(~cs_n));

endmodule

/* spim_fifo.sv */
/*
  spim word fifo
  circular buffer with fill level, soft flush and sticky overflow/underflow flags
*/
`timescale 1ns/1ps

module spim_fifo #(
  parameter int FIFO_ADDR_WIDTH = 4
) (
  input  logic                        aclk,
  input  logic                        arst_n,
  input  logic                        push,
  input  logic [spim_pkg::DATA_W-1:0] wdata,
  input  logic                        pop,
  input  logic                        flush,
  input  logic                        clr_sticky,
  output logic [spim_pkg::DATA_W-1:0] rdata,
  output logic [FIFO_ADDR_WIDTH:0]    level,
  output logic                        overflow_sticky,
  output logic                        underflow_sticky
);

  localparam int DEPTH = 1 << FIFO_ADDR_WIDTH;

  logic [spim_pkg::DATA_W-1:0] mem [DEPTH];
  logic [FIFO_ADDR_WIDTH-1:0]  wptr;
  logic [FIFO_ADDR_WIDTH-1:0]  rptr;
  logic                        full;
  logic                        empty;
  logic                        wr_en;
  logic                        rd_en;

  assign full  = (level == (FIFO_ADDR_WIDTH+1)'(DEPTH));
  assign empty = (level == '0);
  // push into full drops, pop from empty is ignored
  assign wr_en = push & ~full;
  assign rd_en = pop & ~empty;

  // head word, zero when nothing stored
  assign rdata = empty ? '0 : mem[rptr];

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem[wptr] <= wdata;
    end
  end

  // pointers and fill level
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wptr  <= '0;
      rptr  <= '0;
      level <= '0;
    end else if (flush) begin
      wptr  <= '0;
      rptr  <= '0;
      level <= '0;
    end else begin
      if (wr_en) begin
        wptr <= wptr + 1'b1;
      end
      if (rd_en) begin
        rptr <= rptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  // sticky error flags, a new error wins over clear
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      overflow_sticky  <= 1'b0;
      underflow_sticky <= 1'b0;
    end else begin
      if (clr_sticky) begin
        overflow_sticky  <= 1'b0;
        underflow_sticky <= 1'b0;
      end
      if (push && full) begin
        overflow_sticky <= 1'b1;
      end
      if (pop && empty) begin
        underflow_sticky <= 1'b1;
      end
    end
  end

  a_level_bound : assert property (@(posedge aclk) disable iff (!arst_n)
    level <= (FIFO_ADDR_WIDTH+1)'(DEPTH));

endmodule

/* spim_pkg.sv */
/*
  spim shared definitions
  word width, register map, read default and command/control field positions
*/
package spim_pkg;

  // bus and spi word width
  localparam int DATA_W = 32;

  //////////////////////////////
  // register byte offsets
  //////////////////////////////
  localparam logic [15:0] REG_CMD       = 16'h0000;
  localparam logic [15:0] REG_STATUS    = 16'h000C;
  localparam logic [15:0] REG_DIAG0     = 16'h0010;
  localparam logic [15:0] REG_DIAG1     = 16'h0014;
  localparam logic [15:0] REG_WBUF_PEEK = 16'h0020;
  // data windows, handled by the bus slave
  localparam logic [15:0] REG_WBUF_DATA = 16'h0030;
  localparam logic [15:0] REG_RBUF_DATA = 16'h0038;
  localparam logic [15:0] REG_WBUF_STAT = 16'h0040;
  localparam logic [15:0] REG_WBUF_CTRL = 16'h0044;
  localparam logic [15:0] REG_RBUF_STAT = 16'h0048;
  localparam logic [15:0] REG_RBUF_CTRL = 16'h004C;

  // unmapped reads
  localparam logic [DATA_W-1:0] RDATA_DEFAULT = 32'hdead_beef;

  //////////////////////////////
  // command register fields
  //////////////////////////////
  localparam int CMD_START_BIT = 0;
  // word count minus one
  localparam int CMD_CNT_LSB   = 1;
  localparam int CMD_CNT_MSB   = 4;
  // half bit period minus one, in aclk cycles
  localparam int CMD_DIV_LSB   = 8;
  localparam int CMD_DIV_MSB   = 15;
  // chip select index
  localparam int CMD_CS_LSB    = 30;
  localparam int CMD_CS_MSB    = 31;

  // fifo control register bits
  localparam int CTRL_FLUSH_BIT = 0;
  localparam int CTRL_CLR_BIT   = 1;

  // number of chip selects
  localparam int CS_N_W = 4;

endpackage

/* spim_reg.sv */
/*
  spim register block
  command, status, diagnostics, wbuf peek, fifo status and fifo control
*/
`timescale 1ns/1ps

module spim_reg #(
  parameter int FIFO_ADDR_WIDTH = 4
) (
  input  logic                        aclk,
  input  logic                        arst_n,
  input  logic [spim_pkg::DATA_W-1:0] wdata,
  input  logic                        write,
  input  logic                        read,
  input  logic [15:0]                 addr,
  input  logic                        trans_done,
  input  logic [spim_pkg::DATA_W-1:0] status_in,
  input  logic [spim_pkg::DATA_W-1:0] diag0_in,
  input  logic                        load_diag0,
  input  logic [spim_pkg::DATA_W-1:0] diag1_in,
  input  logic [spim_pkg::DATA_W-1:0] wbuf_head,
  input  logic [FIFO_ADDR_WIDTH:0]    wbuf_level,
  input  logic [FIFO_ADDR_WIDTH:0]    rbuf_level,
  input  logic                        wbuf_overflow_sticky,
  input  logic                        wbuf_underflow_sticky,
  input  logic                        rbuf_overflow_sticky,
  input  logic                        rbuf_underflow_sticky,
  output logic [spim_pkg::DATA_W-1:0] rdata,
  output logic [spim_pkg::DATA_W-1:0] m_cmd,
  output logic                        wbuf_flush,
  output logic                        wbuf_clr,
  output logic                        rbuf_flush,
  output logic                        rbuf_clr
);

  logic [spim_pkg::DATA_W-1:0] status_q;
  logic [spim_pkg::DATA_W-1:0] diag0_q;
  logic [spim_pkg::DATA_W-1:0] diag1_q;
  logic [spim_pkg::DATA_W-1:0] peek_q;
  logic [spim_pkg::DATA_W-1:0] wbuf_stat_q;
  logic [spim_pkg::DATA_W-1:0] rbuf_stat_q;
  logic [spim_pkg::DATA_W-1:0] wbuf_ctrl;
  logic [spim_pkg::DATA_W-1:0] rbuf_ctrl;

  // fifo controls act while the bit is held
  assign wbuf_flush = wbuf_ctrl[spim_pkg::CTRL_FLUSH_BIT];
  assign wbuf_clr   = wbuf_ctrl[spim_pkg::CTRL_CLR_BIT];
  assign rbuf_flush = rbuf_ctrl[spim_pkg::CTRL_FLUSH_BIT];
  assign rbuf_clr   = rbuf_ctrl[spim_pkg::CTRL_CLR_BIT];

  //////////////////////////////
  // writable registers
  //////////////////////////////
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_cmd     <= '0;
      wbuf_ctrl <= '0;
      rbuf_ctrl <= '0;
    end else begin
      // end of transfer beats a software write
      if (trans_done) begin
        m_cmd[spim_pkg::CMD_START_BIT] <= 1'b0;
      end else if (write && addr == spim_pkg::REG_CMD) begin
        m_cmd <= wdata;
      end
      if (write && addr == spim_pkg::REG_WBUF_CTRL) begin
        wbuf_ctrl <= wdata;
      end
      if (write && addr == spim_pkg::REG_RBUF_CTRL) begin
        rbuf_ctrl <= wdata;
      end
    end
  end

  // status side, sampled every cycle
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      status_q    <= '0;
      diag0_q     <= '0;
      diag1_q     <= '0;
      peek_q      <= '0;
      wbuf_stat_q <= '0;
      rbuf_stat_q <= '0;
    end else begin
      status_q <= status_in;
      // last received word
      if (load_diag0) begin
        diag0_q <= diag0_in;
      end
      diag1_q     <= diag1_in;
      peek_q      <= wbuf_head;
      // level in [15:8], overflow bit 1, underflow bit 0
      wbuf_stat_q <= {16'b0, 8'(wbuf_level), 6'b0,
                      wbuf_overflow_sticky, wbuf_underflow_sticky};
      rbuf_stat_q <= {16'b0, 8'(rbuf_level), 6'b0,
                      rbuf_overflow_sticky, rbuf_underflow_sticky};
    end
  end

  //////////////////////////////
  // read mux
  //////////////////////////////
  always_comb begin
    case (addr)
      spim_pkg::REG_CMD:       rdata = {m_cmd[31:30], 14'b0, m_cmd[15:0]};
      spim_pkg::REG_STATUS:    rdata = status_q;
      spim_pkg::REG_DIAG0:     rdata = diag0_q;
      spim_pkg::REG_DIAG1:     rdata = diag1_q;
      spim_pkg::REG_WBUF_PEEK: rdata = peek_q;
      spim_pkg::REG_WBUF_STAT: rdata = wbuf_stat_q;
      spim_pkg::REG_WBUF_CTRL: rdata = wbuf_ctrl;
      spim_pkg::REG_RBUF_STAT: rdata = rbuf_stat_q;
      spim_pkg::REG_RBUF_CTRL: rdata = rbuf_ctrl;
      default:                 rdata = spim_pkg::RDATA_DEFAULT;
    endcase
  end

  // data window accesses go to the fifos, never here
  a_no_window : assert property (@(posedge aclk) disable iff (!arst_n)
    (read |-> addr != spim_pkg::REG_RBUF_DATA) and
    (write |-> addr != spim_pkg::REG_WBUF_DATA));

endmodule

/* spim_tb.sv */
/*
  spim testbench
  wishbone bus tasks, inverting spi slave model, reference functions, checks
  and directed plus random transfer tests
*/
`timescale 1ns/1ps

module spim_tb;

  // 12 transfers at most, 16 words of 32 bits at 8 cycles per bit
  localparam int NUM_XFERS      = 12;
  localparam int TIMEOUT_CYCLES = NUM_XFERS * 16 * 32 * 8 + 2000;

  logic        aclk;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [15:0] wb_adr;
  logic [31:0] wb_dat_i;
  logic        miso;
  logic        wb_ack;
  logic [31:0] wb_dat_o;
  logic        sclk;
  logic        mosi;
  logic [3:0]  cs_n;

  int          err_count;
  int          tests_run;
  int          tests_failed;
  int          cycle_count;
  int unsigned seed_ret;
  logic        cs_low_seen;
  logic        cs_bad_seen;
  logic        sclk_prev;
  int          sclk_rises;
  int          sclk_high_cycles;
  logic [31:0] mosi_bits;

  tb_clk_gen #(
    .PERIOD_NS    (40),
    .RESET_CYCLES (4)
  ) u_clk (
    .aclk   (aclk),
    .arst_n (arst_n)
  );

  spim_top #(
    .FIFO_ADDR_WIDTH (4)
  ) dut (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .miso     (miso),
    .wb_ack   (wb_ack),
    .wb_dat_o (wb_dat_o),
    .sclk     (sclk),
    .mosi     (mosi),
    .cs_n     (cs_n)
  );

  //////////////////////////////
  // spi slave model and monitors
  //////////////////////////////
  // slave echoes the inverse of mosi
  always @(posedge aclk) begin
    #2;
    miso = ~mosi;
  end

  // only cs_n[2] may go low
  always @(negedge aclk) begin
    if (arst_n && cs_n != 4'b1111) begin
      if (cs_n == 4'b1011) begin
        cs_low_seen = 1'b1;
      end else begin
        cs_bad_seen = 1'b1;
      end
      // sclk high time and mosi bit at each rising sclk
      if (sclk) begin
        sclk_high_cycles++;
        if (!sclk_prev) begin
          sclk_rises++;
          mosi_bits = {mosi_bits[30:0], mosi};
        end
      end
    end
    sclk_prev = sclk;
  end

  always @(posedge aclk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: no finish after %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $finish;
    end
  end

  //////////////////////////////
  // reference functions
  //////////////////////////////
  // slave inverts every bit
  function automatic logic [31:0] expected_rx(input logic [31:0] word);
    return ~word;
  endfunction

  // bits 29..16 are not stored
  function automatic logic [31:0] cmd_readback(input logic [31:0] cmd);
    return {cmd[31:30], 14'b0, cmd[15:0]};
  endfunction

  function automatic logic [31:0] build_cmd(input int n, input int div, input int cs);
    logic [31:0] c;
    c = '0;
    c[spim_pkg::CMD_START_BIT] = 1'b1;
    c[spim_pkg::CMD_CNT_MSB:spim_pkg::CMD_CNT_LSB] = 4'(n - 1);
    c[spim_pkg::CMD_DIV_MSB:spim_pkg::CMD_DIV_LSB] = 8'(div);
    c[spim_pkg::CMD_CS_MSB:spim_pkg::CMD_CS_LSB] = 2'(cs);
    return c;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_count != errs_before) begin
      tests_failed++;
    end
    $display("[%s] done, %0d errors", name, err_count - errs_before);
  endtask

  //////////////////////////////
  // wishbone master
  //////////////////////////////
  task automatic bus_write(input logic [15:0] adr, input logic [31:0] data);
    @(posedge aclk);
    #2;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_i = data;
    @(negedge aclk);
    while (!wb_ack) @(negedge aclk);
    @(posedge aclk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_read(input logic [15:0] adr, output logic [31:0] data);
    @(posedge aclk);
    #2;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    @(negedge aclk);
    while (!wb_ack) @(negedge aclk);
    data = wb_dat_o;
    @(posedge aclk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // status registers trail the fifos by a cycle
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge aclk);
  endtask

  // pushes the first words, the engine sends zero for the rest
  task automatic run_transfer(input string name, input int n, input int pushed,
                              input int div);
    logic [31:0] words [$];
    logic [31:0] w;
    logic [31:0] rd;
    int          i;
    words.delete();
    for (i = 0; i < n; i++) begin
      w = (i < pushed) ? $urandom : 32'h0;
      if (i < pushed) begin
        bus_write(spim_pkg::REG_WBUF_DATA, w);
      end
      words.push_back(w);
    end
    cs_low_seen      = 1'b0;
    cs_bad_seen      = 1'b0;
    sclk_rises       = 0;
    sclk_high_cycles = 0;
    mosi_bits        = '0;
    bus_write(spim_pkg::REG_CMD, build_cmd(n, div, 2));
    // start bit falls with trans_done
    bus_read(spim_pkg::REG_CMD, rd);
    while (rd[spim_pkg::CMD_START_BIT]) begin
      bus_read(spim_pkg::REG_CMD, rd);
    end
    for (i = 0; i < n; i++) begin
      bus_read(spim_pkg::REG_RBUF_DATA, rd);
      check($sformatf("%s rbuf[%0d]", name, i), expected_rx(words[i]), rd);
    end
    // idle engine, word count only
    bus_read(spim_pkg::REG_STATUS, rd);
    check({name, " status"}, 32'(n), rd);
    bus_read(spim_pkg::REG_DIAG0, rd);
    check({name, " diag0"}, expected_rx(words[n-1]), rd);
    // one rising sclk per bit, high for div+1 cycles, msb first on mosi
    check({name, " sclk rises"}, 32'(32 * n), 32'(sclk_rises));
    check({name, " sclk high cycles"}, 32'(32 * n * (div + 1)), 32'(sclk_high_cycles));
    check({name, " mosi last word"}, words[n-1], mosi_bits);
    if (cs_bad_seen || !cs_low_seen) begin
      $display("%s: chip select 2 was not the only select driven low", name);
      err_count++;
    end
  endtask

  //////////////////////////////
  // tests
  //////////////////////////////
  initial begin
    logic [31:0] rd;
    logic [31:0] v;
    int          e;
    int          k;
    int          n;
    wb_cyc           = 1'b0;
    wb_stb           = 1'b0;
    wb_we            = 1'b0;
    wb_adr           = '0;
    wb_dat_i         = '0;
    miso             = 1'b0;
    err_count        = 0;
    tests_run        = 0;
    tests_failed     = 0;
    cycle_count      = 0;
    cs_low_seen      = 1'b0;
    cs_bad_seen      = 1'b0;
    sclk_prev        = 1'b0;
    sclk_rises       = 0;
    sclk_high_cycles = 0;
    mosi_bits        = '0;
    seed_ret         = $urandom(32'hf853_0ecd);
    wait (arst_n);

    // reset values and unmapped reads
    e = err_count;
    bus_read(spim_pkg::REG_CMD, rd);
    check("reset cmd", 32'h0, rd);
    bus_read(spim_pkg::REG_STATUS, rd);
    check("reset status", 32'h0, rd);
    bus_read(spim_pkg::REG_DIAG0, rd);
    check("reset diag0", 32'h0, rd);
    bus_read(spim_pkg::REG_DIAG1, rd);
    check("reset diag1", 32'h0, rd);
    bus_read(spim_pkg::REG_WBUF_PEEK, rd);
    check("reset peek", 32'h0, rd);
    bus_read(spim_pkg::REG_WBUF_STAT, rd);
    check("reset wbuf stat", 32'h0, rd);
    bus_read(spim_pkg::REG_WBUF_CTRL, rd);
    check("reset wbuf ctrl", 32'h0, rd);
    bus_read(spim_pkg::REG_RBUF_STAT, rd);
    check("reset rbuf stat", 32'h0, rd);
    bus_read(spim_pkg::REG_RBUF_CTRL, rd);
    check("reset rbuf ctrl", 32'h0, rd);
    bus_read(16'h0030, rd);
    check("reset unmapped 0x30", spim_pkg::RDATA_DEFAULT, rd);
    bus_read(16'h0050, rd);
    check("reset unmapped 0x50", spim_pkg::RDATA_DEFAULT, rd);
    finish_test("reset_values", e);

    // command and fifo control readback, start bit kept clear
    e = err_count;
    v = $urandom & ~32'h1;
    bus_write(spim_pkg::REG_CMD, v);
    bus_read(spim_pkg::REG_CMD, rd);
    check("readback cmd", cmd_readback(v), rd);
    bus_write(spim_pkg::REG_CMD, 32'h0);
    v = $urandom | 32'h3;
    bus_write(spim_pkg::REG_RBUF_CTRL, v);
    bus_read(spim_pkg::REG_RBUF_CTRL, rd);
    check("readback rbuf ctrl", v, rd);
    bus_write(spim_pkg::REG_RBUF_CTRL, 32'h0);
    v = $urandom | 32'h3;
    bus_write(spim_pkg::REG_WBUF_CTRL, v);
    bus_read(spim_pkg::REG_WBUF_CTRL, rd);
    check("readback wbuf ctrl", v, rd);
    // pushes vanish while flush is held
    bus_write(spim_pkg::REG_WBUF_DATA, $urandom);
    bus_write(spim_pkg::REG_WBUF_DATA, $urandom);
    bus_read(spim_pkg::REG_WBUF_STAT, rd);
    check("readback held flush level", 32'h0, 32'(rd[15:8]));
    bus_write(spim_pkg::REG_WBUF_CTRL, 32'h0);
    bus_write(spim_pkg::REG_WBUF_DATA, $urandom);
    bus_write(spim_pkg::REG_WBUF_DATA, $urandom);
    bus_read(spim_pkg::REG_WBUF_STAT, rd);
    check("readback level", 32'h2, 32'(rd[15:8]));
    bus_write(spim_pkg::REG_WBUF_CTRL, 32'h1);
    idle_cycles(2);
    bus_read(spim_pkg::REG_WBUF_STAT, rd);
    check("readback flushed level", 32'h0, 32'(rd[15:8]));
    bus_write(spim_pkg::REG_WBUF_CTRL, 32'h0);
    finish_test("cmd_readback", e);

    // every word queued before start
    e = err_count;
    n = 1 + ($urandom % 8);
    run_transfer("transfer", n, n, $urandom % 4);
    finish_test("transfer", e);

    // three words, only one queued
    e = err_count;
    run_transfer("underflow", 3, 1, $urandom % 4);
    bus_read(spim_pkg::REG_WBUF_STAT, rd);
    check("underflow flag set", 32'h1, 32'(rd[0]));
    bus_write(spim_pkg::REG_WBUF_CTRL, 32'h2);
    idle_cycles(2);
    bus_write(spim_pkg::REG_WBUF_CTRL, 32'h0);
    bus_read(spim_pkg::REG_WBUF_STAT, rd);
    check("underflow flag cleared", 32'h0, 32'(rd[0]));
    finish_test("underflow", e);

    // empty pop, then 17 pushes into a 16 deep fifo
    e = err_count;
    bus_read(spim_pkg::REG_RBUF_DATA, rd);
    check("overflow empty pop", 32'h0, rd);
    bus_read(spim_pkg::REG_RBUF_STAT, rd);
    check("overflow rbuf underflow", 32'h1, 32'(rd[0]));
    for (k = 0; k < 17; k++) begin
      bus_write(spim_pkg::REG_WBUF_DATA, $urandom);
    end
    bus_read(spim_pkg::REG_WBUF_STAT, rd);
    check("overflow level", 32'd16, 32'(rd[15:8]));
    check("overflow flag", 32'h1, 32'(rd[1]));
    bus_write(spim_pkg::REG_WBUF_CTRL, 32'h1);
    idle_cycles(2);
    bus_read(spim_pkg::REG_WBUF_STAT, rd);
    check("overflow flushed level", 32'h0, 32'(rd[15:8]));
    // leave both fifos empty with clean flags
    bus_write(spim_pkg::REG_WBUF_CTRL, 32'h3);
    bus_write(spim_pkg::REG_RBUF_CTRL, 32'h3);
    idle_cycles(2);
    bus_write(spim_pkg::REG_WBUF_CTRL, 32'h0);
    bus_write(spim_pkg::REG_RBUF_CTRL, 32'h0);
    finish_test("overflow_flush", e);

    for (k = 0; k < 10; k++) begin
      e = err_count;
      run_transfer($sformatf("random_%0d", k), 1 + ($urandom % 8), 8, $urandom % 4);
      finish_test($sformatf("random_%0d", k), e);
    end

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* spim_top.sv */
/*
  spim top level
  wishbone slave, register block, shift engine, write and read fifos
*/
`timescale 1ns/1ps

module spim_top #(
  parameter int FIFO_ADDR_WIDTH = 4
) (
  input  logic                        aclk,
  input  logic                        arst_n,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [15:0]                 wb_adr,
  input  logic [spim_pkg::DATA_W-1:0] wb_dat_i,
  input  logic                        miso,
  output logic                        wb_ack,
  output logic [spim_pkg::DATA_W-1:0] wb_dat_o,
  output logic                        sclk,
  output logic                        mosi,
  output logic [spim_pkg::CS_N_W-1:0] cs_n
);

  // bus slave to register block
  logic                        reg_write;
  logic                        reg_read;
  logic [15:0]                 reg_addr;
  logic [spim_pkg::DATA_W-1:0] reg_wdata;
  logic [spim_pkg::DATA_W-1:0] reg_rdata;
  logic [spim_pkg::DATA_W-1:0] m_cmd;

  // fifo side
  logic                        wbuf_push;
  logic                        wbuf_pop;
  logic                        wbuf_flush;
  logic                        wbuf_clr;
  logic [spim_pkg::DATA_W-1:0] wbuf_rdata;
  logic [FIFO_ADDR_WIDTH:0]    wbuf_level;
  logic                        wbuf_ovf;
  logic                        wbuf_unf;
  logic                        rbuf_push;
  logic                        rbuf_pop;
  logic                        rbuf_flush;
  logic                        rbuf_clr;
  logic [spim_pkg::DATA_W-1:0] rbuf_wdata;
  logic [spim_pkg::DATA_W-1:0] rbuf_rdata;
  logic [FIFO_ADDR_WIDTH:0]    rbuf_level;
  logic                        rbuf_ovf;
  logic                        rbuf_unf;

  // engine status
  logic                        word_done;
  logic                        trans_done;
  logic                        busy;
  logic [4:0]                  words_sent;
  logic [spim_pkg::DATA_W-1:0] bit_state;

  spim_wb_slave u_wb_slave (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_i   (wb_dat_i),
    .reg_rdata  (reg_rdata),
    .rbuf_rdata (rbuf_rdata),
    .wb_ack     (wb_ack),
    .wb_dat_o   (wb_dat_o),
    .reg_write  (reg_write),
    .reg_read   (reg_read),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .wbuf_push  (wbuf_push),
    .rbuf_pop   (rbuf_pop)
  );

  spim_reg #(
    .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
  ) u_reg (
    .aclk                  (aclk),
    .arst_n                (arst_n),
    .wdata                 (reg_wdata),
    .write                 (reg_write),
    .read                  (reg_read),
    .addr                  (reg_addr),
    .trans_done            (trans_done),
    // busy in bit 31, word count in [4:0]
    .status_in             ({busy, 26'b0, words_sent}),
    .diag0_in              (rbuf_wdata),
    .load_diag0            (word_done),
    .diag1_in              (bit_state),
    .wbuf_head             (wbuf_rdata),
    .wbuf_level            (wbuf_level),
    .rbuf_level            (rbuf_level),
    .wbuf_overflow_sticky  (wbuf_ovf),
    .wbuf_underflow_sticky (wbuf_unf),
    .rbuf_overflow_sticky  (rbuf_ovf),
    .rbuf_underflow_sticky (rbuf_unf),
    .rdata                 (reg_rdata),
    .m_cmd                 (m_cmd),
    .wbuf_flush            (wbuf_flush),
    .wbuf_clr              (wbuf_clr),
    .rbuf_flush            (rbuf_flush),
    .rbuf_clr              (rbuf_clr)
  );

  spim_engine #(
    .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
  ) u_engine (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .cmd        (m_cmd),
    .wbuf_data  (wbuf_rdata),
    .miso       (miso),
    .wbuf_pop   (wbuf_pop),
    .rbuf_push  (rbuf_push),
    .rbuf_data  (rbuf_wdata),
    .word_done  (word_done),
    .trans_done (trans_done),
    .busy       (busy),
    .words_sent (words_sent),
    .bit_state  (bit_state),
    .sclk       (sclk),
    .mosi       (mosi),
    .cs_n       (cs_n)
  );

  // words to send, filled from the bus
  spim_fifo #(
    .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
  ) u_wbuf (
    .aclk             (aclk),
    .arst_n           (arst_n),
    .push             (wbuf_push),
    .wdata            (reg_wdata),
    .pop              (wbuf_pop),
    .flush            (wbuf_flush),
    .clr_sticky       (wbuf_clr),
    .rdata            (wbuf_rdata),
    .level            (wbuf_level),
    .overflow_sticky  (wbuf_ovf),
    .underflow_sticky (wbuf_unf)
  );

  // received words, drained from the bus
  spim_fifo #(
    .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
  ) u_rbuf (
    .aclk             (aclk),
    .arst_n           (arst_n),
    .push             (rbuf_push),
    .wdata            (rbuf_wdata),
    .pop              (rbuf_pop),
    .flush            (rbuf_flush),
    .clr_sticky       (rbuf_clr),
    .rdata            (rbuf_rdata),
    .level            (rbuf_level),
    .overflow_sticky  (rbuf_ovf),
    .underflow_sticky (rbuf_unf)
  );

endmodule

/* spim_wb_slave.sv */
/*
  spim wishbone classic slave
  two cycle access; one strobe per ack, data windows mapped to fifo push/pop
*/
`timescale 1ns/1ps

module spim_wb_slave (
  input  logic                        aclk,
  input  logic                        arst_n,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [15:0]                 wb_adr,
  input  logic [spim_pkg::DATA_W-1:0] wb_dat_i,
  input  logic [spim_pkg::DATA_W-1:0] reg_rdata,
  input  logic [spim_pkg::DATA_W-1:0] rbuf_rdata,
  output logic                        wb_ack,
  output logic [spim_pkg::DATA_W-1:0] wb_dat_o,
  output logic                        reg_write,
  output logic                        reg_read,
  output logic [15:0]                 reg_addr,
  output logic [spim_pkg::DATA_W-1:0] reg_wdata,
  output logic                        wbuf_push,
  output logic                        rbuf_pop
);

  logic req;
  logic live;
  logic is_wwin;
  logic is_rwin;

  // new request, not yet acked
  assign req  = wb_cyc & wb_stb & ~wb_ack;
  // ack cycle of a held request
  assign live = wb_cyc & wb_stb & wb_ack;

  assign is_wwin = (wb_adr == spim_pkg::REG_WBUF_DATA);
  assign is_rwin = (wb_adr == spim_pkg::REG_RBUF_DATA);

  assign wbuf_push = live & wb_we & is_wwin;
  assign rbuf_pop  = live & ~wb_we & is_rwin;
  assign reg_write = live & wb_we & ~is_wwin;
  assign reg_read  = live & ~wb_we & ~is_rwin;
  assign reg_addr  = wb_adr;
  assign reg_wdata = wb_dat_i;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  // read data captured as ack rises, fifo head popped in the ack cycle
  always_ff @(posedge aclk) begin
    if (req && !wb_we) begin
      wb_dat_o <= is_rwin ? rbuf_rdata : reg_rdata;
    end
  end

  a_ack_in_cycle : assert property (@(posedge aclk) disable iff (!arst_n)
    wb_ack |-> (wb_cyc && wb_stb));

endmodule

/* tb_clk_gen.sv */
/*
  testbench clock and reset
  free running aclk, arst_n held low for a few cycles
*/
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic aclk,
  output logic arst_n
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

  // release a little after an edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    #2;
    arst_n = 1'b1;
  end

endmodule
